/* hdl/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Command queue
`define DMA_QUEUE_DEPTH 8

// Word memory behind the arbiter
`define SRAM_WORDS 256

// Status register values
`define DMA_STATUS_BUSY 32'hffff_ffff
`define DMA_STATUS_IDLE 32'h0000_0000

`endif

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	typedef logic [31:0] bus_word_t;
	typedef logic [31:0] bus_addr_t; // Byte address, stepped by 4

	typedef struct packed {
		logic      request;
		logic      rw; // High for write
		bus_addr_t address;
		bus_word_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic      ready; // One cycle pulse
		bus_word_t rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* hdl/dma_pkg.sv */
`default_nettype none

package dma_pkg;

	typedef enum logic [1:0] {
		FILL = 2'd1,
		COPY = 2'd2
	} dma_op_t;

	typedef struct packed {
		dma_op_t           op;
		bus_pkg::bus_word_t value_or_from; // Fill value or source address
		bus_pkg::bus_addr_t to;
		bus_pkg::bus_word_t count;         // Words minus one
	} dma_cmd_t;

	typedef logic [1:0] dma_reg_t;

	localparam dma_reg_t REG_VALUE = 2'd0;
	localparam dma_reg_t REG_DEST  = 2'd1;
	localparam dma_reg_t REG_COUNT = 2'd2;
	localparam dma_reg_t REG_CTRL  = 2'd3; // Op code on write, status on read

	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		LOAD_CMD     = 4'd1,
		FILL_REQ     = 4'd2,
		FILL_WAIT    = 4'd3,
		COPY_RD_REQ  = 4'd4,
		COPY_RD_WAIT = 4'd5,
		COPY_WR_REQ  = 4'd6,
		COPY_WR_WAIT = 4'd7
	} dma_state_t;

endpackage

`default_nettype wire

/* hdl/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module cmd_fifo (
	input  wire                i_clock,
	input  wire                i_reset,
	input  wire                i_write,
	input  wire dma_pkg::dma_cmd_t i_wdata,
	input  wire                i_read,
	output dma_pkg::dma_cmd_t  o_rdata,
	output logic               o_empty,
	output logic               o_full
);
	import dma_pkg::*;

	localparam int DEPTH = `DMA_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	dma_cmd_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_write;
	logic             do_read;

	assign o_empty  = (count == '0);
	assign o_full   = (count == (PTR_W+1)'(DEPTH));
	assign do_write = i_write && !o_full;
	assign do_read  = i_read && !o_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge i_clock) begin
		if (do_write)
			mem[wr_ptr] <= i_wdata;
		if (do_read)
			o_rdata <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* hdl/dma_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_engine (
	input  wire                    i_clock,
	input  wire                    i_reset,

	input  wire                    i_reg_request,
	input  wire                    i_reg_write,
	input  wire dma_pkg::dma_reg_t i_reg_address,
	input  wire bus_pkg::bus_word_t i_reg_wdata,
	output bus_pkg::bus_word_t     o_reg_rdata,
	output logic                   o_reg_ready,

	input  wire                    i_stall,

	output bus_pkg::bus_req_t      o_bus_req,
	input  wire bus_pkg::bus_rsp_t i_bus_rsp
);
	import bus_pkg::*;
	import dma_pkg::*;

	dma_state_t state;
	dma_cmd_t   wr_cmd;   // Fields gathered from register writes
	dma_cmd_t   cur_cmd;  // Command being executed
	dma_cmd_t   push_cmd;
	dma_cmd_t   fifo_rdata;
	bus_word_t  data;     // Copy word in flight
	logic       fifo_empty;
	logic       fifo_full;
	logic       fifo_read;
	logic       cmd_write;
	logic       reg_accept;
	logic       busy;

	assign cmd_write  = i_reg_write && (i_reg_address == REG_CTRL);
	assign reg_accept = i_reg_request && !o_reg_ready && !(cmd_write && fifo_full);
	assign busy       = !fifo_empty || (state != IDLE);
	assign fifo_read  = (state == IDLE) && !fifo_empty;

	always_comb begin
		push_cmd    = wr_cmd;
		push_cmd.op = dma_op_t'(i_reg_wdata[1:0]);
	end

	cmd_fifo u_queue (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_write (reg_accept && cmd_write), // One push per request
		.i_wdata (push_cmd),
		.i_read  (fifo_read),
		.o_rdata (fifo_rdata),
		.o_empty (fifo_empty),
		.o_full  (fifo_full)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_reg_ready <= 1'b0;
		else if (!i_reg_request)
			o_reg_ready <= 1'b0;
		else if (reg_accept)
			o_reg_ready <= 1'b1; // Held while queue full
	end

	always_ff @(posedge i_clock) begin
		if (reg_accept) begin
			if (i_reg_write) begin
				case (i_reg_address)
					REG_VALUE: wr_cmd.value_or_from <= i_reg_wdata;
					REG_DEST:  wr_cmd.to <= i_reg_wdata;
					REG_COUNT: wr_cmd.count <= i_reg_wdata;
					default:   wr_cmd.op <= dma_op_t'(i_reg_wdata[1:0]);
				endcase
			end else begin
				case (i_reg_address)
					REG_VALUE: o_reg_rdata <= wr_cmd.value_or_from;
					REG_DEST:  o_reg_rdata <= wr_cmd.to;
					REG_COUNT: o_reg_rdata <= wr_cmd.count;
					default:   o_reg_rdata <= busy ? `DMA_STATUS_BUSY : `DMA_STATUS_IDLE;
				endcase
			end
		end
	end

	// Transfer state machine
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state             <= IDLE;
			o_bus_req.request <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (!fifo_empty)
						state <= LOAD_CMD;
				end

				LOAD_CMD: begin
					cur_cmd <= fifo_rdata;
					case (fifo_rdata.op)
						FILL:    state <= FILL_REQ;
						COPY:    state <= COPY_RD_REQ;
						default: state <= IDLE; // Invalid op dropped
					endcase
				end

				FILL_REQ: begin
					if (!i_stall) begin
						o_bus_req <= '{request: 1'b1, rw: 1'b1, address: cur_cmd.to,
							wdata: cur_cmd.value_or_from};
						state <= FILL_WAIT;
					end
				end

				COPY_RD_REQ: begin
					if (!i_stall) begin
						o_bus_req.request <= 1'b1;
						o_bus_req.rw      <= 1'b0;
						o_bus_req.address <= cur_cmd.value_or_from;
						state             <= COPY_RD_WAIT;
					end
				end

				COPY_RD_WAIT: begin
					if (i_bus_rsp.ready) begin
						o_bus_req.request     <= 1'b0;
						data                  <= i_bus_rsp.rdata;
						cur_cmd.value_or_from <= cur_cmd.value_or_from + 32'd4;
						state                 <= COPY_WR_REQ;
					end
				end

				COPY_WR_REQ: begin
					if (!i_stall) begin
						o_bus_req <= '{request: 1'b1, rw: 1'b1, address: cur_cmd.to,
							wdata: data};
						state <= COPY_WR_WAIT;
					end
				end

				FILL_WAIT, COPY_WR_WAIT: begin
					if (i_bus_rsp.ready) begin
						o_bus_req.request <= 1'b0;
						cur_cmd.to        <= cur_cmd.to + 32'd4;
						if (cur_cmd.count != '0) begin
							cur_cmd.count <= cur_cmd.count - 1'b1;
							state <= (state == FILL_WAIT) ? FILL_REQ : COPY_RD_REQ;
						end else begin
							state <= IDLE;
						end
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire                    i_clock,
	input  wire                    i_reset,

	input  wire bus_pkg::bus_req_t i_host_req,
	output bus_pkg::bus_rsp_t      o_host_rsp,
	input  wire bus_pkg::bus_req_t i_dma_req,
	output bus_pkg::bus_rsp_t      o_dma_rsp,

	output bus_pkg::bus_req_t      o_mem_req,
	input  wire bus_pkg::bus_rsp_t i_mem_rsp
);
	logic busy;      // Transaction in progress
	logic owner;     // High when the engine owns the bus
	logic last_dma;  // Engine was served last
	logic pick_dma;
	logic grant_dma;

	// Round robin only matters when both wait
	always_comb begin
		if (i_host_req.request && i_dma_req.request)
			pick_dma = !last_dma;
		else
			pick_dma = i_dma_req.request;
	end

	assign grant_dma = busy ? owner : pick_dma;
	assign o_mem_req = grant_dma ? i_dma_req : i_host_req;

	assign o_host_rsp = '{ready: i_mem_rsp.ready && !grant_dma, rdata: i_mem_rsp.rdata};
	assign o_dma_rsp  = '{ready: i_mem_rsp.ready && grant_dma, rdata: i_mem_rsp.rdata};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy     <= 1'b0;
			owner    <= 1'b0;
			last_dma <= 1'b0;
		end else if (busy) begin
			if (i_mem_rsp.ready) begin
				busy     <= 1'b0; // Released the cycle after ready
				last_dma <= owner;
			end
		end else if (i_host_req.request || i_dma_req.request) begin
			busy  <= 1'b1;
			owner <= pick_dma;
		end
	end

endmodule

`default_nettype wire

/* hdl/sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module sram_slave (
	input  wire                    i_clock,
	input  wire                    i_reset,
	input  wire bus_pkg::bus_req_t i_req,
	output bus_pkg::bus_rsp_t      o_rsp
);
	import bus_pkg::*;

	localparam int WORDS  = `SRAM_WORDS;
	localparam int ADDR_W = $clog2(WORDS);

	bus_word_t         mem [WORDS];
	bus_word_t         rdata;
	logic              ready;
	logic [ADDR_W-1:0] index;
	logic              access;

	assign index  = i_req.address[ADDR_W+1:2]; // Word index from byte address
	assign access = i_req.request && !ready;
	assign o_rsp  = '{ready: ready, rdata: rdata};

	always_ff @(posedge i_clock) begin
		if (i_reset)
			ready <= 1'b0;
		else
			ready <= access; // One pulse per request
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_req.rw)
				mem[index] <= i_req.wdata;
			else
				rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

/* hdl/dma_system.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_system (
	input  wire                     i_clock,
	input  wire                     i_reset,

	input  wire                     i_reg_request,
	input  wire                     i_reg_write,
	input  wire dma_pkg::dma_reg_t  i_reg_address,
	input  wire bus_pkg::bus_word_t i_reg_wdata,
	output bus_pkg::bus_word_t      o_reg_rdata,
	output logic                    o_reg_ready,

	input  wire                     i_stall,

	input  wire bus_pkg::bus_req_t  i_host_req,
	output bus_pkg::bus_rsp_t       o_host_rsp
);
	import bus_pkg::*;

	bus_req_t dma_req;
	bus_rsp_t dma_rsp;
	bus_req_t mem_req;
	bus_rsp_t mem_rsp;

	dma_engine u_dma (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_reg_request (i_reg_request),
		.i_reg_write   (i_reg_write),
		.i_reg_address (i_reg_address),
		.i_reg_wdata   (i_reg_wdata),
		.o_reg_rdata   (o_reg_rdata),
		.o_reg_ready   (o_reg_ready),
		.i_stall       (i_stall),
		.o_bus_req     (dma_req),
		.i_bus_rsp     (dma_rsp)
	);

	bus_arbiter u_arbiter (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_host_req (i_host_req),
		.o_host_rsp (o_host_rsp),
		.i_dma_req  (dma_req),
		.o_dma_rsp  (dma_rsp),
		.o_mem_req  (mem_req),
		.i_mem_rsp  (mem_rsp)
	);

	sram_slave u_sram (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_req   (mem_req),
		.o_rsp   (mem_rsp)
	);

endmodule

`default_nettype wire

/* testbench/dma_system_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_system_checker (
	input wire                     i_clock,
	input wire                     i_reset,
	input wire bus_pkg::bus_req_t  i_host_req,
	input wire bus_pkg::bus_rsp_t  i_host_rsp,
	input wire bus_pkg::bus_req_t  i_dma_req,
	input wire bus_pkg::bus_rsp_t  i_dma_rsp,
	input wire bus_pkg::bus_req_t  i_mem_req,
	input wire bus_pkg::bus_rsp_t  i_mem_rsp,
	input wire                     i_reg_ready
);
	int unsigned fail_count = 0;

	// Pending requests held until ready
	host_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_host_req.request && !i_host_rsp.ready |=> $stable(i_host_req))
		else begin
			$error("host request changed before ready");
			fail_count++;
		end

	dma_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_dma_req.request && !i_dma_rsp.ready |=> $stable(i_dma_req))
		else begin
			$error("engine request changed before ready");
			fail_count++;
		end

	sram_ready_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_rsp.ready |-> i_mem_req.request)
		else begin
			$error("SRAM ready without a request");
			fail_count++;
		end

	// Ready only reaches the master whose request the SRAM served
	host_ready_granted: assert property (@(posedge i_clock) disable iff (i_reset)
		i_host_rsp.ready |-> i_host_req.request && ($past(i_mem_req) == i_host_req))
		else begin
			$error("host saw ready without the grant");
			fail_count++;
		end

	dma_ready_granted: assert property (@(posedge i_clock) disable iff (i_reset)
		i_dma_rsp.ready |-> i_dma_req.request && ($past(i_mem_req) == i_dma_req))
		else begin
			$error("engine saw ready without the grant");
			fail_count++;
		end

	reg_ready_after_reset: assert property (@(posedge i_clock)
		i_reset |=> !i_reg_ready)
		else begin
			$error("register ready high after reset");
			fail_count++;
		end

endmodule

bind dma_system dma_system_checker u_checker (
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_host_req  (i_host_req),
	.i_host_rsp  (o_host_rsp),
	.i_dma_req   (dma_req),
	.i_dma_rsp   (dma_rsp),
	.i_mem_req   (mem_req),
	.i_mem_rsp   (mem_rsp),
	.i_reg_ready (o_reg_ready)
);

`default_nettype wire

/* testbench/dma_system_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_system_tb;
	import bus_pkg::*;
	import dma_pkg::*;

	localparam int TIMEOUT = 2000; // Per wait
	localparam int ROWS    = 6;

	typedef struct packed {
		logic [1:0]  op;
		bus_word_t   value;  // Fill value or source address
		bus_addr_t   dest;
		bus_word_t   count;  // Words minus one
		logic [15:0] stall;  // Cycles i_stall stays high once queued work starts
		logic        host;   // Host traffic during the transfer
		logic [3:0]  extra;  // Commands queued behind the first one
	} row_t;

	// op, value or source, destination, count, stall, host, extra
	row_t rows [ROWS] = '{
		'{2'd1, 32'h5a5a_0001, 32'h040, 32'd5,  16'd0,   1'b0, 4'd0},
		'{2'd2, 32'h0000_0040, 32'h100, 32'd7,  16'd0,   1'b0, 4'd0},
		'{2'd2, 32'h0000_0080, 32'h180, 32'd15, 16'd0,   1'b1, 4'd0},
		'{2'd1, 32'h0bad_f000, 32'h200, 32'd3,  16'd160, 1'b0, 4'd9},
		'{2'd0, 32'h1111_1111, 32'h080, 32'd3,  16'd0,   1'b0, 4'd0},
		'{2'd3, 32'h2222_2222, 32'h0c0, 32'd3,  16'd0,   1'b0, 4'd0}
	};

	logic      clock = 1'b0;
	logic      reset;
	logic      reg_request;
	logic      reg_write;
	dma_reg_t  reg_address;
	bus_word_t reg_wdata;
	bus_word_t reg_rdata;
	logic      reg_ready;
	logic      stall;
	bus_req_t  host_req;
	bus_rsp_t  host_rsp;
	bus_word_t model [`SRAM_WORDS]; // Reference memory
	int        errors = 0;
	int        checks = 0;

	dma_system u_dut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_reg_request (reg_request),
		.i_reg_write   (reg_write),
		.i_reg_address (reg_address),
		.i_reg_wdata   (reg_wdata),
		.o_reg_rdata   (reg_rdata),
		.o_reg_ready   (reg_ready),
		.i_stall       (stall),
		.i_host_req    (host_req),
		.o_host_rsp    (host_rsp)
	);

	always #4 clock = ~clock;

	function automatic int word_of(input bus_addr_t address);
		return int'((address >> 2) % `SRAM_WORDS);
	endfunction

	task automatic end_run();
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_dut.u_checker.fail_count);
		if (errors == 0 && u_dut.u_checker.fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		errors++;
		end_run();
	endtask

	task automatic reg_access(input logic write, input dma_reg_t index, input bus_word_t wdata,
			output bus_word_t rdata, output int latency);
		latency = 0;
		@(posedge clock);
		reg_request <= 1'b1;
		reg_write   <= write;
		reg_address <= index;
		reg_wdata   <= wdata;
		@(negedge clock);
		while (!reg_ready) begin
			if (latency == TIMEOUT)
				abort_run("timeout waiting for o_reg_ready");
			latency++;
			@(negedge clock);
		end
		rdata = reg_rdata;
		@(posedge clock);
		reg_request <= 1'b0;
	endtask

	// Latency returned is that of the op code write
	task automatic issue_command(input logic [1:0] op, input bus_word_t value,
			input bus_addr_t dest, input bus_word_t count, output int latency);
		bus_word_t ignored;
		reg_access(1'b1, REG_VALUE, value, ignored, latency);
		reg_access(1'b1, REG_DEST, dest, ignored, latency);
		reg_access(1'b1, REG_COUNT, count, ignored, latency);
		reg_access(1'b1, REG_CTRL, {30'd0, op}, ignored, latency);
	endtask

	task automatic host_access(input logic write, input bus_addr_t address,
			input bus_word_t wdata, output bus_word_t rdata);
		int waited;
		waited = 0;
		@(posedge clock);
		host_req <= '{request: 1'b1, rw: write, address: address, wdata: wdata};
		@(negedge clock);
		while (!host_rsp.ready) begin
			if (waited == TIMEOUT)
				abort_run("timeout waiting for host ready");
			waited++;
			@(negedge clock);
		end
		rdata = host_rsp.rdata;
		@(posedge clock);
		host_req.request <= 1'b0;
	endtask

	task automatic check_status(input bus_word_t expected);
		bus_word_t status;
		int        latency;
		reg_access(1'b0, REG_CTRL, '0, status, latency);
		checks++;
		if (status !== expected) begin
			errors++;
			$display("mismatch o_reg_rdata status: got 0x%08h expected 0x%08h", status, expected);
		end
	endtask

	task automatic wait_idle();
		bus_word_t status;
		int        latency;
		int        polls;
		polls  = 0;
		status = `DMA_STATUS_BUSY;
		while (status !== `DMA_STATUS_IDLE) begin
			if (polls == TIMEOUT)
				abort_run("timeout waiting for the DMA status to read idle");
			polls++;
			reg_access(1'b0, REG_CTRL, '0, status, latency);
		end
	endtask

	task automatic apply_to_model(input logic [1:0] op, input bus_word_t value,
			input bus_addr_t dest, input bus_word_t count);
		int i;
		for (i = 0; i <= int'(count); i++) begin
			if (op == 2'd1)
				model[word_of(dest) + i] = value;
			else if (op == 2'd2)
				model[word_of(dest) + i] = model[word_of(value) + i];
		end
	endtask

	// Includes the word just past the range
	task automatic compare_range(input bus_addr_t dest, input bus_word_t count);
		bus_word_t got;
		bus_addr_t address;
		int        i;
		for (i = 0; i <= int'(count) + 1; i++) begin
			address = dest + 4 * i;
			host_access(1'b0, address, '0, got);
			checks++;
			if (got !== model[word_of(address)]) begin
				errors++;
				$display("mismatch host rdata at 0x%08h: got 0x%08h expected 0x%08h",
					address, got, model[word_of(address)]);
			end
		end
	endtask

	initial begin
		row_t      r;
		bus_word_t value;
		bus_word_t got;
		int        latency;
		int        i;
		int        k;
		void'($urandom(38));
		reset       = 1'b1;
		reg_request = 1'b0;
		reg_write   = 1'b0;
		reg_address = '0;
		reg_wdata   = '0;
		stall       = 1'b0;
		host_req    = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		for (i = 0; i < `SRAM_WORDS; i++) begin
			value    = $urandom;
			model[i] = value;
			host_access(1'b1, 4 * i, value, got);
		end

		for (i = 0; i < ROWS; i++) begin
			r = rows[i];
			if (r.stall != 0) begin
				@(posedge clock);
				stall <= 1'b1;
			end
			issue_command(r.op, r.value, r.dest, r.count, latency);

			if (r.host) begin
				// Separate region, served between engine transactions
				for (k = 0; k < 4; k++) begin
					value = $urandom;
					model[word_of(32'h3c0) + k] = value;
					host_access(1'b1, 32'h3c0 + 4 * k, value, got);
				end
				compare_range(32'h3c0, 32'd3);
				check_status(`DMA_STATUS_BUSY); // Copy still running
			end

			if (r.stall != 0) begin
				repeat (4) begin
					check_status(`DMA_STATUS_BUSY);
					host_access(1'b0, r.dest, '0, got);
					checks++;
					if (got !== model[word_of(r.dest)]) begin
						errors++;
						$display("mismatch host rdata at 0x%08h: got 0x%08h expected 0x%08h",
							r.dest, got, model[word_of(r.dest)]);
					end
				end
				fork
					begin
						for (k = 1; k <= int'(r.extra); k++)
							issue_command(r.op, r.value + k, r.dest + 32 * k, r.count, latency);
					end
					begin
						repeat (int'(r.stall)) @(posedge clock);
						stall <= 1'b0;
					end
				join
				if (r.extra > `DMA_QUEUE_DEPTH) begin
					checks++;
					if (latency < 20) begin
						errors++;
						$display("command accepted after %0d cycles while the queue was full",
							latency);
					end
				end
				check_status(`DMA_STATUS_BUSY);
			end

			wait_idle();
			for (k = 0; k <= int'(r.extra); k++)
				apply_to_model(r.op, r.value + k, r.dest + 32 * k, r.count);
			for (k = 0; k <= int'(r.extra); k++)
				compare_range(r.dest + 32 * k, r.count);
		end
		end_run();
	end

endmodule

`default_nettype wire

/* dma_system.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/dma_pkg.sv
hdl/cmd_fifo.sv
hdl/dma_engine.sv
hdl/bus_arbiter.sv
hdl/sram_slave.sv
hdl/dma_system.sv
testbench/dma_system_checker.sv
testbench/dma_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dma_system_tb
FILELIST  ?= dma_system.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+1000

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
